//--- hdl/bridge_defines.svh
/*
 * Buffer sizes and the TX space threshold of the host-to-stream bridge.
 * Include this header wherever a FIFO depth or threshold is needed.
 */

`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// TX word buffer, 32 entries of flagged words
`define BRIDGE_TX_WORD_DEPTH_LOG2 5

// Both line buffers, 8 entries each
`define BRIDGE_LINE_DEPTH_LOG2 3

// RX word buffer, 32 entries
`define BRIDGE_RX_WORD_DEPTH_LOG2 5

// Queue of complete RX packet lengths
`define BRIDGE_LEN_DEPTH_LOG2 2

// Free TX word entries the host needs before a burst of writes
`define BRIDGE_TX_BURST 8

`endif

//--- hdl/stream_pkg.sv
/*
 * Payload types of the internal valid/ready streams.
 * Words are 16 bits with frame flags, lines pack two words little-endian.
 */

package stream_pkg;

   // One 16-bit word with its frame flags
   typedef struct packed {
      logic        eof;
      logic        sof;
      logic [15:0] data;
   } word18_t;

   // Two words per line, the first word in data[15:0]
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } line36_t;

   // occ encodings
   localparam logic [1:0] OCC_FULL       = 2'd0;
   // Last line of a frame with only the lower half in use
   localparam logic [1:0] OCC_LOWER_ONLY = 2'd2;

endpackage

//--- hdl/host_pkg.sv
/*
 * Host-side types: the bus data word and the status struct
 * that the bridge returns to the host.
 */

package host_pkg;

   typedef logic [15:0] host_word_t;

   // rx_frame_len is counted in 16-bit words
   typedef struct packed {
      logic       tx_have_space;
      logic       rx_have_data;
      logic       bus_error;
      host_word_t rx_frame_len;
   } host_status_t;

endpackage

//--- hdl/stream_fifo.sv
/*
 * Synchronous show-ahead FIFO on a register array.
 * The payload type is a parameter, so one block serves words, lines and lengths.
 * space_o and used_o give the free and occupied entry counts.
 */

module stream_fifo #(
   parameter type payload_t  = logic,
   parameter int  depth_log2 = 4
) (
   input  logic                  fifo_clk,
   input  logic                  reset_i,
   input  logic                  clear_i,
   input  payload_t              in_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output payload_t              out_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i,
   output logic [depth_log2:0]   space_o,
   output logic [depth_log2:0]   used_o
);

   localparam logic [depth_log2:0] full_count = {1'b1, {depth_log2{1'b0}}};

   payload_t              mem [full_count];
   logic [depth_log2-1:0] wr_ptr;
   logic [depth_log2-1:0] rd_ptr;
   logic [depth_log2:0]   used;
   logic                  push;
   logic                  pop;

   assign in_ready_o  = (used != full_count);
   assign out_valid_o = (used != '0);
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;

   // Head of the buffer is always on the output
   assign out_o   = mem[rd_ptr];
   assign used_o  = used;
   assign space_o = full_count - used;

   always_ff @(posedge fifo_clk) begin
      if (push) begin
         mem[wr_ptr] <= in_i;
      end
   end

   always_ff @(posedge fifo_clk) begin
      if (reset_i || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         used <= used + {{depth_log2{1'b0}}, push} - {{depth_log2{1'b0}}, pop};
      end
   end

endmodule

//--- hdl/tx_framer.sv
/*
 * Host write side of the TX path. Each write strobe becomes a flagged word
 * in the same cycle; sof and eof follow the programmed frame length.
 * Writes into a full buffer are dropped and reported as a bus error.
 */

`include "bridge_defines.svh"

module tx_framer (
   input  logic                               fifo_clk,
   input  logic                               reset_i,
   input  logic                               clear_i,
   input  logic                               wr_en_i,
   input  host_pkg::host_word_t               wr_data_i,
   input  host_pkg::host_word_t               frame_len_i,
   output stream_pkg::word18_t                out_o,
   output logic                               out_valid_o,
   input  logic                               out_ready_i,
   input  logic [`BRIDGE_TX_WORD_DEPTH_LOG2:0] space_i,
   output logic                               have_space_o,
   output logic                               bus_error_o
);

   host_pkg::host_word_t word_cnt;
   logic                 last_word;
   logic                 accept;

   // A frame length of zero or one makes every word a whole frame
   assign last_word = ((word_cnt + 16'd1) >= frame_len_i);
   assign accept    = wr_en_i & out_ready_i;

   assign out_valid_o = wr_en_i;
   assign out_o.data  = wr_data_i;
   assign out_o.sof   = (word_cnt == '0);
   assign out_o.eof   = last_word;

   assign have_space_o = (space_i >= `BRIDGE_TX_BURST);

   always_ff @(posedge fifo_clk) begin
      if (reset_i || clear_i) begin
         word_cnt    <= '0;
         bus_error_o <= 1'b0;
      end else begin
         if (accept) begin
            word_cnt <= last_word ? '0 : word_cnt + 16'd1;
         end
         // Dropped write, count stays where it was
         bus_error_o <= wr_en_i & ~out_ready_i;
      end
   end

endmodule

//--- hdl/line_packer.sv
/*
 * Packs pairs of flagged words into 36-bit lines, first word in the low half.
 * A frame that ends on a lower half closes its line early with occ set.
 * The finished line is held until the line buffer takes it.
 */

module line_packer (
   input  logic                fifo_clk,
   input  logic                reset_i,
   input  logic                clear_i,
   input  stream_pkg::word18_t in_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output stream_pkg::line36_t out_o,
   output logic                out_valid_o,
   input  logic                out_ready_i
);

   stream_pkg::word18_t lo_word;
   stream_pkg::line36_t line_next;
   logic                have_lo;
   logic                take;
   logic                close;

   // No new word while a finished line is stalled
   assign in_ready_o = ~out_valid_o | out_ready_i;
   assign take       = in_valid_i & in_ready_o;
   assign close      = take & (have_lo | in_i.eof);

   always_comb begin
      if (have_lo) begin
         line_next.occ  = stream_pkg::OCC_FULL;
         line_next.eof  = lo_word.eof | in_i.eof;
         line_next.sof  = lo_word.sof;
         line_next.data = {in_i.data, lo_word.data};
      end else begin
         line_next.occ  = stream_pkg::OCC_LOWER_ONLY;
         line_next.eof  = 1'b1;
         line_next.sof  = in_i.sof;
         line_next.data = {16'h0000, in_i.data};
      end
   end

   always_ff @(posedge fifo_clk) begin
      if (take && !have_lo) begin
         lo_word <= in_i;
      end
      if (close) begin
         out_o <= line_next;
      end
   end

   always_ff @(posedge fifo_clk) begin
      if (reset_i || clear_i) begin
         have_lo     <= 1'b0;
         out_valid_o <= 1'b0;
      end else begin
         if (close) begin
            out_valid_o <= 1'b1;
         end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
         end
         if (take) begin
            have_lo <= ~have_lo & ~in_i.eof;
         end
      end
   end

endmodule

//--- hdl/line_unpacker.sv
/*
 * Splits 36-bit lines back into flagged words, low half first.
 * A line with occ set yields only its lower half, which carries eof.
 * A new line is taken only after the held one has been fully sent.
 */

module line_unpacker (
   input  logic                fifo_clk,
   input  logic                reset_i,
   input  logic                clear_i,
   input  stream_pkg::line36_t in_i,
   input  logic                in_valid_i,
   output logic                in_ready_o,
   output stream_pkg::word18_t out_o,
   output logic                out_valid_o,
   input  logic                out_ready_i
);

   stream_pkg::line36_t line_q;
   logic                upper;
   logic                lower_only;
   logic                last_word;

   assign in_ready_o  = ~out_valid_o;
   assign lower_only  = (line_q.occ == stream_pkg::OCC_LOWER_ONLY);
   assign last_word   = upper | lower_only;

   always_comb begin
      if (upper) begin
         out_o.data = line_q.data[31:16];
         out_o.sof  = 1'b0;
         out_o.eof  = line_q.eof;
      end else begin
         out_o.data = line_q.data[15:0];
         out_o.sof  = line_q.sof;
         out_o.eof  = line_q.eof & lower_only;
      end
   end

   always_ff @(posedge fifo_clk) begin
      if (in_valid_i && in_ready_o) begin
         line_q <= in_i;
      end
   end

   always_ff @(posedge fifo_clk) begin
      if (reset_i || clear_i) begin
         out_valid_o <= 1'b0;
         upper       <= 1'b0;
      end else if (!out_valid_o) begin
         out_valid_o <= in_valid_i;
      end else if (out_ready_i) begin
         out_valid_o <= ~last_word;
         upper       <= ~last_word;
      end
   end

endmodule

//--- hdl/rx_packet_watcher.sv
/*
 * Watches both sides of the RX word buffer. Counts words of the packet
 * being written, queues the length of each complete packet and tells the
 * host when one is ready. A read with no packet waiting is a bus error.
 */

`include "bridge_defines.svh"

module rx_packet_watcher (
   input  logic                 fifo_clk,
   input  logic                 reset_i,
   input  logic                 clear_i,
   input  stream_pkg::word18_t  wr_word_i,
   input  logic                 wr_fire_i,
   input  stream_pkg::word18_t  rd_word_i,
   input  logic                 rd_fire_i,
   input  logic                 rd_en_i,
   output logic                 have_data_o,
   output host_pkg::host_word_t frame_len_o,
   output logic                 bus_error_o
);

   host_pkg::host_word_t            wr_count;
   host_pkg::host_word_t            len_head;
   logic                            len_push;
   logic                            len_pop;
   logic [`BRIDGE_LEN_DEPTH_LOG2:0] pkt_count;

   assign len_push = wr_fire_i & wr_word_i.eof;
   assign len_pop  = rd_fire_i & rd_word_i.eof;

   // Occupancy of the length queue is the number of complete packets
   stream_fifo #(
      .payload_t  (host_pkg::host_word_t),
      .depth_log2 (`BRIDGE_LEN_DEPTH_LOG2)
   ) len_queue_i (
      .fifo_clk    (fifo_clk),
      .reset_i     (reset_i),
      .clear_i     (clear_i),
      .in_i        (wr_count + 16'd1),
      .in_valid_i  (len_push),
      .in_ready_o  (),
      .out_o       (len_head),
      .out_valid_o (),
      .out_ready_i (len_pop),
      .space_o     (),
      .used_o      (pkt_count)
   );

   assign have_data_o = (pkt_count != '0);
   assign frame_len_o = have_data_o ? len_head : '0;

   always_ff @(posedge fifo_clk) begin
      if (reset_i || clear_i) begin
         wr_count    <= '0;
         bus_error_o <= 1'b0;
      end else begin
         if (wr_fire_i) begin
            wr_count <= wr_word_i.eof ? '0 : wr_count + 16'd1;
         end
         bus_error_o <= rd_en_i & ~have_data_o;
      end
   end

endmodule

//--- hdl/host_fifo_bridge.sv
/*
 * Host-bus to stream bridge, FIFO clock domain. Host writes are framed,
 * buffered and packed into lines; incoming lines are unpacked and buffered
 * for host reads. Status goes back to the host as one packed struct.
 */

`include "bridge_defines.svh"

module host_fifo_bridge (
   input  logic                   fifo_clk,
   input  logic                   reset_i,
   input  logic                   clear_tx_i,
   input  logic                   clear_rx_i,
   input  logic                   host_wr_en_i,
   input  host_pkg::host_word_t   host_wr_data_i,
   input  host_pkg::host_word_t   tx_frame_len_i,
   input  logic                   host_rd_en_i,
   output stream_pkg::word18_t    host_rd_data_o,
   output stream_pkg::line36_t    tx_line_o,
   output logic                   tx_line_valid_o,
   input  logic                   tx_line_ready_i,
   input  stream_pkg::line36_t    rx_line_i,
   input  logic                   rx_line_valid_i,
   output logic                   rx_line_ready_o,
   output host_pkg::host_status_t status_o
);

   //////////////////////////////////////////////////////////////////////
   // TX path

   stream_pkg::word18_t                tx_word, tx_word_b;
   logic                               tx_word_valid, tx_word_ready;
   logic                               tx_word_b_valid, tx_word_b_ready;
   logic [`BRIDGE_TX_WORD_DEPTH_LOG2:0] tx_space;
   stream_pkg::line36_t                tx_line;
   logic                               tx_line_valid, tx_line_ready;
   logic                               tx_have_space, bus_error_tx;

   tx_framer framer_i (
      .fifo_clk, .reset_i, .clear_i(clear_tx_i),
      .wr_en_i(host_wr_en_i), .wr_data_i(host_wr_data_i), .frame_len_i(tx_frame_len_i),
      .out_o(tx_word), .out_valid_o(tx_word_valid), .out_ready_i(tx_word_ready),
      .space_i(tx_space), .have_space_o(tx_have_space), .bus_error_o(bus_error_tx));

   stream_fifo #(.payload_t(stream_pkg::word18_t), .depth_log2(`BRIDGE_TX_WORD_DEPTH_LOG2))
   tx_word_fifo_i (
      .fifo_clk, .reset_i, .clear_i(clear_tx_i),
      .in_i(tx_word), .in_valid_i(tx_word_valid), .in_ready_o(tx_word_ready),
      .out_o(tx_word_b), .out_valid_o(tx_word_b_valid), .out_ready_i(tx_word_b_ready),
      .space_o(tx_space), .used_o());

   // Little-endian packing, first word in the low half
   line_packer packer_i (
      .fifo_clk, .reset_i, .clear_i(clear_tx_i),
      .in_i(tx_word_b), .in_valid_i(tx_word_b_valid), .in_ready_o(tx_word_b_ready),
      .out_o(tx_line), .out_valid_o(tx_line_valid), .out_ready_i(tx_line_ready));

   stream_fifo #(.payload_t(stream_pkg::line36_t), .depth_log2(`BRIDGE_LINE_DEPTH_LOG2))
   tx_line_fifo_i (
      .fifo_clk, .reset_i, .clear_i(clear_tx_i),
      .in_i(tx_line), .in_valid_i(tx_line_valid), .in_ready_o(tx_line_ready),
      .out_o(tx_line_o), .out_valid_o(tx_line_valid_o), .out_ready_i(tx_line_ready_i),
      .space_o(), .used_o());

   //////////////////////////////////////////////////////////////////////
   // RX path

   stream_pkg::line36_t rx_line;
   logic                rx_line_valid, rx_line_ready;
   stream_pkg::word18_t rx_word;
   logic                rx_word_valid, rx_word_ready;
   logic                rx_word_b_valid, rx_word_b_ready;
   logic                rx_have_data, bus_error_rx;
   host_pkg::host_word_t rx_frame_len;

   stream_fifo #(.payload_t(stream_pkg::line36_t), .depth_log2(`BRIDGE_LINE_DEPTH_LOG2))
   rx_line_fifo_i (
      .fifo_clk, .reset_i, .clear_i(clear_rx_i),
      .in_i(rx_line_i), .in_valid_i(rx_line_valid_i), .in_ready_o(rx_line_ready_o),
      .out_o(rx_line), .out_valid_o(rx_line_valid), .out_ready_i(rx_line_ready),
      .space_o(), .used_o());

   line_unpacker unpacker_i (
      .fifo_clk, .reset_i, .clear_i(clear_rx_i),
      .in_i(rx_line), .in_valid_i(rx_line_valid), .in_ready_o(rx_line_ready),
      .out_o(rx_word), .out_valid_o(rx_word_valid), .out_ready_i(rx_word_ready));

   stream_fifo #(.payload_t(stream_pkg::word18_t), .depth_log2(`BRIDGE_RX_WORD_DEPTH_LOG2))
   rx_word_fifo_i (
      .fifo_clk, .reset_i, .clear_i(clear_rx_i),
      .in_i(rx_word), .in_valid_i(rx_word_valid), .in_ready_o(rx_word_ready),
      .out_o(host_rd_data_o), .out_valid_o(rx_word_b_valid), .out_ready_i(rx_word_b_ready),
      .space_o(), .used_o());

   // Reads only pop once a whole packet is buffered
   assign rx_word_b_ready = host_rd_en_i & rx_have_data;

   rx_packet_watcher watcher_i (
      .fifo_clk, .reset_i, .clear_i(clear_rx_i),
      .wr_word_i(rx_word), .wr_fire_i(rx_word_valid & rx_word_ready),
      .rd_word_i(host_rd_data_o), .rd_fire_i(rx_word_b_valid & rx_word_b_ready),
      .rd_en_i(host_rd_en_i), .have_data_o(rx_have_data),
      .frame_len_o(rx_frame_len), .bus_error_o(bus_error_rx));

   //////////////////////////////////////////////////////////////////////
   // Host status

   logic bus_error;

   // Sticky until either direction is cleared
   always_ff @(posedge fifo_clk) begin
      if (reset_i || clear_tx_i || clear_rx_i) begin
         bus_error <= 1'b0;
      end else if (bus_error_tx || bus_error_rx) begin
         bus_error <= 1'b1;
      end
   end

   assign status_o.tx_have_space = tx_have_space;
   assign status_o.rx_have_data  = rx_have_data;
   assign status_o.bus_error     = bus_error;
   assign status_o.rx_frame_len  = rx_frame_len;

endmodule

//--- test/bridge_tb.sv
/*
 * Self-checking testbench for the host-to-stream bridge. A table of tests
 * drives TX frames, RX packets, bus errors and clears through the DUT and
 * compares lines, read words and status with values built from the packing rules.
 */

module bridge_tb;

   // Error action codes are 0 none, 1 read while empty, 2 TX overflow and 3 clear during a stall
   typedef struct packed {
      bit [63:0] name;
      int        tx_len;
      int        rx_len;
      int        rx_pkts;
      int        bp_mode;
      int        err_act;
   } test_t;

   localparam int NUM_TESTS = 9;

   test_t tests [NUM_TESTS] = '{
      '{"tx_len_1", 1, 0, 0, 0, 0},
      '{"tx_len_4", 4, 0, 0, 0, 0},
      '{"tx_len_7", 7, 0, 0, 0, 0},
      '{"tx_bkprs", 12, 0, 0, 1, 0},
      '{"rx_pkt_5", 0, 5, 1, 0, 0},
      '{"rx_two_q", 0, 4, 2, 0, 0},
      '{"rd_empty", 0, 0, 0, 0, 1},
      '{"tx_ovflw", 60, 0, 0, 0, 2},
      '{"tx_clear", 5, 0, 0, 0, 3}
   };

   logic                   fifo_clk;
   logic                   reset_i, clear_tx_i, clear_rx_i;
   logic                   host_wr_en_i, host_rd_en_i;
   host_pkg::host_word_t   host_wr_data_i;
   host_pkg::host_word_t   tx_frame_len_i;
   stream_pkg::word18_t    host_rd_data_o;
   stream_pkg::line36_t    tx_line_o;
   logic                   tx_line_valid_o, tx_line_ready_i;
   stream_pkg::line36_t    rx_line_i;
   logic                   rx_line_valid_i, rx_line_ready_o;
   host_pkg::host_status_t status_o;

   bit [63:0]           cur_name;
   int                  value_errors = 0;
   int                  other_errors = 0;
   int                  cycle_count = 0;
   int                  cycle_limit;
   logic [31:0]         lcg_state;
   logic [15:0]         words [$];
   stream_pkg::line36_t line_q [$];
   stream_pkg::word18_t exp_words [$];

   host_fifo_bridge dut_i (.*);

   initial begin
      fifo_clk = 1'b0;
      forever #4 fifo_clk = ~fifo_clk;
   end

   // Run limit scales with the words in the table
   always @(posedge fifo_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("%s: timeout, the test made no progress within %0d cycles",
                  cur_name, cycle_count);
         $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks and stimulus helpers

   task automatic check_value(input string what, input logic [35:0] expected,
                              input logic [35:0] actual);
      if (expected !== actual) begin
         value_errors++;
         $display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
      end
   endtask

   task automatic report_failure(input string msg);
      other_errors++;
      $display("%s: %s", cur_name, msg);
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic void make_words(input int n);
      logic [31:0] r;
      words.delete();
      for (int i = 0; i < n; i++) begin
         r = lcg_next();
         words.push_back(r[31:16]);
      end
   endfunction

   // Little-endian pairs with the first word in the low half
   function automatic void build_lines(input int n);
      stream_pkg::line36_t line;
      line_q.delete();
      for (int i = 0; i < n; i += 2) begin
         line.sof = (i == 0);
         if (i + 1 < n) begin
            line.occ  = 2'd0;
            line.eof  = (i + 2 == n);
            line.data = {words[i + 1], words[i]};
         end else begin
            // Odd tail uses only the lower half
            line.occ  = 2'd2;
            line.eof  = 1'b1;
            line.data = {16'h0000, words[i]};
         end
         line_q.push_back(line);
      end
   endfunction

   task automatic check_idle();
      @(posedge fifo_clk);
      check_value("idle line valid", 36'(0), 36'(tx_line_valid_o));
      check_value("idle rx ready", 36'(1), 36'(rx_line_ready_o));
      check_value("idle tx space", 36'(1), 36'(status_o.tx_have_space));
      check_value("idle rx data", 36'(0), 36'(status_o.rx_have_data));
      check_value("idle bus error", 36'(0), 36'(status_o.bus_error));
   endtask

   task automatic pulse_clear(input bit tx);
      if (tx) begin
         clear_tx_i <= 1'b1;
      end else begin
         clear_rx_i <= 1'b1;
      end
      @(posedge fifo_clk);
      clear_tx_i      <= 1'b0;
      clear_rx_i      <= 1'b0;
      tx_line_ready_i <= 1'b1;
   endtask

   task automatic run_tx(input int n, input int bp);
      int                  wr_idx;
      bit                  held_valid;
      stream_pkg::line36_t held;
      stream_pkg::line36_t exp_line;
      logic [31:0]         r;
      make_words(n);
      build_lines(n);
      tx_frame_len_i <= 16'(n);
      wr_idx     = 0;
      held_valid = 1'b0;
      while (wr_idx < n || line_q.size() != 0) begin
         @(posedge fifo_clk);
         // A stalled line must not move
         if (held_valid) begin
            check_value("held line valid", 36'(1), 36'(tx_line_valid_o));
            check_value("held line", 36'(held), 36'(tx_line_o));
         end
         held_valid = 1'b0;
         if (tx_line_valid_o && !tx_line_ready_i) begin
            held       = tx_line_o;
            held_valid = 1'b1;
         end else if (tx_line_valid_o && line_q.size() == 0) begin
            report_failure("a line came out after the frame was complete");
         end else if (tx_line_valid_o) begin
            exp_line = line_q.pop_front();
            check_value("line", 36'(exp_line), 36'(tx_line_o));
         end
         if (wr_idx < n) begin
            host_wr_en_i   <= 1'b1;
            host_wr_data_i <= words[wr_idx];
            wr_idx++;
         end else begin
            host_wr_en_i <= 1'b0;
         end
         if (bp != 0) begin
            r = lcg_next();
            tx_line_ready_i <= r[20];
         end
      end
      host_wr_en_i    <= 1'b0;
      tx_line_ready_i <= 1'b1;
   endtask

   task automatic send_rx_packet(input int n);
      stream_pkg::word18_t w;
      make_words(n);
      for (int i = 0; i < n; i++) begin
         w.data = words[i];
         w.sof  = (i == 0);
         w.eof  = (i == n - 1);
         exp_words.push_back(w);
      end
      build_lines(n);
      @(posedge fifo_clk);
      rx_line_valid_i <= 1'b1;
      rx_line_i       <= line_q[0];
      while (line_q.size() != 0) begin
         @(posedge fifo_clk);
         if (rx_line_ready_o) begin
            line_q.delete(0);
            if (line_q.size() != 0) begin
               rx_line_i <= line_q[0];
            end else begin
               rx_line_valid_i <= 1'b0;
            end
         end
      end
   endtask

   task automatic read_rx_packet(input int n, input bit more);
      stream_pkg::word18_t exp_w;
      @(posedge fifo_clk);
      while (!status_o.rx_have_data) @(posedge fifo_clk);
      check_value("frame length", 36'(n), 36'(status_o.rx_frame_len));
      host_rd_en_i <= 1'b1;
      for (int k = 0; k < n; k++) begin
         @(posedge fifo_clk);
         exp_w = exp_words.pop_front();
         check_value("read word", 36'(exp_w), 36'(host_rd_data_o));
         if (k == n - 1) begin
            host_rd_en_i <= 1'b0;
         end
      end
      @(posedge fifo_clk);
      check_value("have data after packet", 36'(more), 36'(status_o.rx_have_data));
   endtask

   task automatic read_empty();
      @(posedge fifo_clk);
      host_rd_en_i <= 1'b1;
      @(posedge fifo_clk);
      host_rd_en_i <= 1'b0;
      repeat (2) @(posedge fifo_clk);
      check_value("bus error after empty read", 36'(1), 36'(status_o.bus_error));
      pulse_clear(1'b0);
   endtask

   // Writes with the line output stalled
   task automatic stall_writes(input int n, input int frame_len);
      make_words(n);
      tx_frame_len_i  <= 16'(frame_len);
      tx_line_ready_i <= 1'b0;
      for (int i = 0; i < n; i++) begin
         @(posedge fifo_clk);
         if (status_o.bus_error && status_o.tx_have_space) begin
            report_failure("bus error came while tx_have_space was still high");
         end
         host_wr_en_i   <= 1'b1;
         host_wr_data_i <= words[i];
      end
      @(posedge fifo_clk);
      host_wr_en_i <= 1'b0;
   endtask

   task automatic tx_overflow(input int n);
      stall_writes(n, n);
      @(posedge fifo_clk);
      check_value("bus error after overflow", 36'(1), 36'(status_o.bus_error));
      check_value("tx space after overflow", 36'(0), 36'(status_o.tx_have_space));
      check_value("stalled line valid", 36'(1), 36'(tx_line_valid_o));
      pulse_clear(1'b1);
   endtask

   // The frame is left open and the next one must start with sof again
   task automatic clear_stalled(input int n);
      stall_writes(n, 2 * n);
      while (!tx_line_valid_o) @(posedge fifo_clk);
      pulse_clear(1'b1);
      check_idle();
      run_tx(n, 0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      reset_i         = 1'b1;
      clear_tx_i      = 1'b0;
      clear_rx_i      = 1'b0;
      host_wr_en_i    = 1'b0;
      host_wr_data_i  = '0;
      tx_frame_len_i  = 16'd1;
      host_rd_en_i    = 1'b0;
      tx_line_ready_i = 1'b1;
      rx_line_i       = '0;
      rx_line_valid_i = 1'b0;
      lcg_state       = 32'd18447;
      cycle_limit     = 200;
      for (int t = 0; t < NUM_TESTS; t++) begin
         cycle_limit += 40 * (tests[t].tx_len + tests[t].rx_len * tests[t].rx_pkts);
      end
      cur_name = "reset   ";
      repeat (5) @(posedge fifo_clk);
      reset_i <= 1'b0;
      check_idle();
      for (int t = 0; t < NUM_TESTS; t++) begin
         cur_name = tests[t].name;
         case (tests[t].err_act)
            1: read_empty();
            2: tx_overflow(tests[t].tx_len);
            3: clear_stalled(tests[t].tx_len);
            default: begin
               if (tests[t].tx_len != 0) begin
                  run_tx(tests[t].tx_len, tests[t].bp_mode);
               end
               // Each packet is one word shorter than the one before
               for (int p = 0; p < tests[t].rx_pkts; p++) begin
                  send_rx_packet(tests[t].rx_len - p);
               end
               for (int p = 0; p < tests[t].rx_pkts; p++) begin
                  read_rx_packet(tests[t].rx_len - p, p < tests[t].rx_pkts - 1);
               end
            end
         endcase
         check_idle();
      end
      $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/host_pkg.sv
hdl/stream_fifo.sv
hdl/tx_framer.sv
hdl/line_packer.sv
hdl/line_unpacker.sv
hdl/rx_packet_watcher.sv
hdl/host_fifo_bridge.sv
test/bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module bridge_tb -Mdir obj_dir -o sim_bridge
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_bridge > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi

exit 0
